// ==== verilog.f ====
+incdir+tests
design/decode_pkg.sv
design/instr_buffer.sv
design/decoder.sv
design/int_regfile.sv
design/issue_reg.sv
design/decode_stage.sv
tests/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_decode_stage \
  -o sim_tb || exit 1

out=$(./obj_dir/sim_tb 2>&1)
echo "$out"
echo "$out" | grep -q "^TB PASSED$" && exit 0 || exit 1

// ==== tests/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Expected decode of one word, built field by field from the ISA formats.
function automatic decoder_out_type model_decode(input instr_t w);
  decoder_out_type d;
  logic [2:0] f3;
  logic rd_nz;
  xlen_t imm_i;
  f3 = w[14:12];
  rd_nz = |w[11:7];
  imm_i = {{21{w[31]}}, w[30:20]};
  d = '0;
  d.waddr = w[11:7];
  d.raddr1 = w[19:15];
  d.raddr2 = w[24:20];
  d.caddr = w[31:20];
  d.valid = 1'b1;
  case (w[6:0])
    opcode_lui, opcode_auipc : begin
      d.lui = (w[6:0] == opcode_lui);
      d.auipc = ~d.lui;
      d.imm = {w[31:12], 12'h000};
      d.wren = rd_nz;
    end
    opcode_jal : begin
      d.jal = 1'b1;
      d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      d.wren = rd_nz;
    end
    opcode_jalr : begin
      d.jalr = 1'b1;
      d.imm = imm_i;
      d.wren = rd_nz;
      d.rden1 = 1'b1;
    end
    opcode_branch : begin
      d.branch = 1'b1;
      d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      d.rden1 = 1'b1;
      d.rden2 = 1'b1;
      case (f3)
        3'd0 : d.bcu_op.bcu_beq = 1'b1;
        3'd1 : d.bcu_op.bcu_bne = 1'b1;
        3'd4 : d.bcu_op.bcu_blt = 1'b1;
        3'd5 : d.bcu_op.bcu_bge = 1'b1;
        3'd6 : d.bcu_op.bcu_bltu = 1'b1;
        3'd7 : d.bcu_op.bcu_bgeu = 1'b1;
        default : d.valid = 1'b0;
      endcase
    end
    opcode_load : begin
      d.load = 1'b1;
      d.imm = imm_i;
      d.wren = rd_nz;
      d.rden1 = 1'b1;
      case (f3)
        3'd0 : d.lsu_op.lsu_lb = 1'b1;
        3'd1 : d.lsu_op.lsu_lh = 1'b1;
        3'd2 : d.lsu_op.lsu_lw = 1'b1;
        3'd4 : d.lsu_op.lsu_lbu = 1'b1;
        3'd5 : d.lsu_op.lsu_lhu = 1'b1;
        default : d.valid = 1'b0;
      endcase
    end
    opcode_store : begin
      d.store = 1'b1;
      d.imm = {{21{w[31]}}, w[30:25], w[11:7]};
      d.rden1 = 1'b1;
      d.rden2 = 1'b1;
      case (f3)
        3'd0 : d.lsu_op.lsu_sb = 1'b1;
        3'd1 : d.lsu_op.lsu_sh = 1'b1;
        3'd2 : d.lsu_op.lsu_sw = 1'b1;
        default : d.valid = 1'b0;
      endcase
    end
    opcode_immediate, opcode_register : begin
      d.imm = (w[6:0] == opcode_immediate) ? imm_i : 32'h0;
      d.wren = rd_nz;
      d.rden1 = 1'b1;
      d.rden2 = (w[6:0] == opcode_register);
      if (d.rden2 && w[25]) begin
        d.mul = ~f3[2];
        d.div = f3[2];
        if (f3[2]) d.div_op = 4'b1000 >> f3[1:0]; // div, divu, rem, remu.
        else d.mul_op = 4'b1000 >> f3[1:0];
      end else begin
        case (f3)
          3'd0 : begin
            d.alu_op.alu_sub = d.rden2 & w[30];
            d.alu_op.alu_add = ~(d.rden2 & w[30]);
          end
          3'd1 : d.alu_op.alu_sll = 1'b1;
          3'd2 : d.alu_op.alu_slt = 1'b1;
          3'd3 : d.alu_op.alu_sltu = 1'b1;
          3'd4 : d.alu_op.alu_xor = 1'b1;
          3'd5 : begin
            d.alu_op.alu_sra = w[30];
            d.alu_op.alu_srl = ~w[30];
          end
          3'd6 : d.alu_op.alu_or = 1'b1;
          default : d.alu_op.alu_and = 1'b1;
        endcase
        if (!d.rden2 && f3[1:0] == 2'b01 && w[25]) d.valid = 1'b0;
      end
    end
    opcode_fence : begin
      d.fence = (f3 < 3'd2);
      d.valid = d.fence;
    end
    opcode_system : begin
      d.imm = {27'h0, w[19:15]};
      if (f3 == 3'd0) begin
        d.ecall = (w[31:20] == csr_ecall);
        d.ebreak = (w[31:20] == csr_ebreak);
        d.mret = (w[31:20] == csr_mret);
        d.wfi = (w[31:20] == csr_wfi);
        d.valid = d.ecall | d.ebreak | d.mret | d.wfi;
      end else if (f3 == 3'd4) begin
        d.valid = 1'b0;
      end else begin
        d.csr = 1'b1;
        d.wren = rd_nz;
        d.rden1 = ~f3[2];
        case (f3)
          3'd1 : d.csr_op.csrrw = 1'b1;
          3'd2 : d.csr_op.csrrs = 1'b1;
          3'd3 : d.csr_op.csrrc = 1'b1;
          3'd5 : d.csr_op.csrrwi = 1'b1;
          3'd6 : d.csr_op.csrrsi = 1'b1;
          default : d.csr_op.csrrci = 1'b1;
        endcase
        // Swap forms always write, set and clear only with a nonzero source.
        d.cwren = (f3[1:0] == 2'b01) ? 1'b1 : |w[19:15];
        d.crden = (f3[1:0] == 2'b01) ? rd_nz : 1'b1;
      end
    end
    default : d.valid = 1'b0;
  endcase
  if (w == nop_instr) begin
    d.alu_op = '0;
    d.nop = 1'b1;
  end
  return d;
endfunction

// Packet expected at issue, operands from the shadow registers.
function automatic issue_pkt_t expect_issue(input fetch_pkt_t f);
  issue_pkt_t p;
  p.pc = f.pc;
  p.ctrl = model_decode(f.instr);
  p.rs1_data = p.ctrl.rden1 ? shadow_regs[p.ctrl.raddr1] : 32'h0;
  p.rs2_data = p.ctrl.rden2 ? shadow_regs[p.ctrl.raddr2] : 32'h0;
  return p;
endfunction

`endif

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ps

module tb_decode_stage
  import decode_pkg::*;
();

  localparam int n_writes = 40;
  localparam int n_random = 600;
  localparam int n_latency = 8;
  localparam int n_bypass = 8;
  localparam int total_items = n_writes + n_random + n_latency + n_bypass;
  localparam int watchdog_ns = 4 * total_items * 4 + 16 * 4;

  logic clock;
  logic arst_n;
  logic fetch_valid;
  fetch_pkt_t fetch_pkt;
  logic fetch_ready;
  logic issue_valid;
  issue_pkt_t issue_pkt;
  logic issue_ready;
  logic wb_en;
  reg_idx_t wb_addr;
  xlen_t wb_data;

  xlen_t shadow_regs [32]; // x0 stays zero.
  issue_pkt_t exp_q[$];
  issue_pkt_t exp_head;
  int exp_count;
  pc_t next_pc;
  logic random_ready;

  `include "tb_decode_model.svh"

  decode_stage #(
    .REG_COUNT (32)
  ) dut_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pkt   (fetch_pkt),
    .fetch_ready (fetch_ready),
    .issue_valid (issue_valid),
    .issue_pkt   (issue_pkt),
    .issue_ready (issue_ready),
    .wb_en       (wb_en),
    .wb_addr     (wb_addr),
    .wb_data     (wb_data)
  );

  always #2 clock = ~clock;

  always @(negedge clock) begin
    if (random_ready) issue_ready = 1'($urandom);
  end

  // Scoreboard pop on each issue transfer.
  always @(posedge clock) begin
    if (arst_n && issue_valid && issue_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      if (exp_q.size() > 0) exp_head <= exp_q[0];
      exp_count <= exp_q.size();
    end
  end

  assert property (@(posedge clock) disable iff (!arst_n)
    (issue_valid && issue_ready) |-> (exp_count > 0 && issue_pkt == exp_head))
  else begin
    $display("CHECK FAILED at %0t: issue packet pc %h instr ctrl mismatch, expected pc %h",
             $time, issue_pkt.pc, exp_head.pc);
    $display("TB FAILED");
    $fatal(1);
  end

  // Both handshake outputs idle through reset.
  assert property (@(posedge clock) $rose(arst_n) |-> (!fetch_ready && !issue_valid))
  else begin
    $display("CHECK FAILED at %0t: fetch_ready or issue_valid high during reset", $time);
    $display("TB FAILED");
    $fatal(1);
  end

  assert property (@(posedge clock) $rose(arst_n) |=> fetch_ready)
  else begin
    $display("CHECK FAILED at %0t: fetch_ready still low after reset release", $time);
    $display("TB FAILED");
    $fatal(1);
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $fatal(1);
  end

  function automatic instr_t random_instr();
    instr_t w;
    int kind;
    w = $urandom;
    kind = $urandom % 14;
    if ($urandom % 3 == 0) w[19:15] = '0;
    if ($urandom % 4 == 0) w[11:7] = '0;
    case (kind)
      0 : w[6:0] = opcode_lui;
      1 : w[6:0] = opcode_auipc;
      2 : w[6:0] = opcode_jal;
      3 : w[6:0] = opcode_jalr;
      4 : w[6:0] = opcode_branch;
      5 : w[6:0] = opcode_load;
      6 : w[6:0] = opcode_store;
      7 : w[6:0] = opcode_immediate;
      8 : begin
        w[6:0] = opcode_register;
        case ($urandom % 3)
          0 : w[31:25] = 7'h00;
          1 : w[31:25] = 7'h20;
          default : w[31:25] = 7'h01; // M extension.
        endcase
      end
      9 : w[6:0] = opcode_system;
      10 : begin
        w[6:0] = opcode_system;
        w[14:12] = 3'b000;
        case ($urandom % 5)
          0 : w[31:20] = csr_ecall;
          1 : w[31:20] = csr_ebreak;
          2 : w[31:20] = csr_mret;
          3 : w[31:20] = csr_wfi;
          default : w[31:20] = 12'($urandom);
        endcase
      end
      11 : w[6:0] = opcode_fence;
      12 : w = w; // Mostly unknown opcodes.
      default : w = nop_instr;
    endcase
    return w;
  endfunction

  task automatic push_expected(input fetch_pkt_t f);
    exp_q.push_back(expect_issue(f));
    exp_head <= exp_q[0];
    exp_count <= exp_q.size();
  endtask

  // Starts on a falling edge and returns at the accepting rising edge.
  task automatic send_item(input instr_t w);
    fetch_pkt.pc = next_pc;
    fetch_pkt.instr = w;
    fetch_valid = 1'b1;
    @(posedge clock);
    while (!fetch_ready) @(posedge clock);
    push_expected(fetch_pkt);
    next_pc += 4;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 200) begin
      @(posedge clock);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("Pipeline did not drain, %0d items still pending", exp_q.size());
      $display("TB FAILED");
      $fatal(1);
    end
    @(negedge clock);
  endtask

  task automatic check_latency();
    int lat;
    logic seen;
    lat = 0;
    seen = 1'b0;
    send_item(random_instr());
    while (lat < 8 && !seen) begin
      @(negedge clock);
      fetch_valid = 1'b0;
      @(posedge clock);
      lat++;
      seen = issue_valid;
    end
    assert (seen && lat == 2)
    else begin
      $display("CHECK FAILED at %0t: issue latency %0d cycles, expected 2", $time, lat);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  // Operand read in the same cycle as its writeback.
  task automatic check_bypass();
    reg_idx_t r;
    xlen_t v;
    r = 5'($urandom % 31 + 1);
    v = $urandom;
    shadow_regs[r] = v;
    @(negedge clock);
    send_item({7'h00, r, r, 3'b000, 5'd1, opcode_register});
    @(negedge clock);
    fetch_valid = 1'b0;
    wb_en = 1'b1;
    wb_addr = r;
    wb_data = v;
    @(negedge clock);
    wb_en = 1'b0;
    wait_drain();
  endtask

  initial begin
    void'($urandom(32'he1d));
    clock = 1'b0;
    arst_n = 1'b0;
    fetch_valid = 1'b0;
    fetch_pkt = '0;
    issue_ready = 1'b0;
    wb_en = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    random_ready = 1'b0;
    exp_head = '0;
    exp_count = 0;
    next_pc = 32'h8000_0000;
    for (int i = 0; i < 32; i++) shadow_regs[i] = '0;
    repeat (16) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;

    for (int i = 0; i < n_writes; i++) begin
      @(negedge clock);
      wb_en = 1'b1;
      wb_addr = (i == 0) ? 5'd0 : 5'($urandom);
      wb_data = $urandom;
      if (wb_addr != '0) shadow_regs[wb_addr] = wb_data;
    end
    @(negedge clock);
    wb_en = 1'b0;

    random_ready = 1'b1;
    for (int i = 0; i < n_random; i++) begin
      @(negedge clock);
      while ($urandom % 4 == 0) begin
        fetch_valid = 1'b0;
        @(negedge clock);
      end
      send_item(random_instr());
    end
    @(negedge clock);
    fetch_valid = 1'b0;
    random_ready = 1'b0;
    issue_ready = 1'b1;
    wait_drain();

    for (int i = 0; i < n_latency; i++) begin
      @(negedge clock);
      check_latency();
    end
    wait_drain();
    for (int i = 0; i < n_bypass; i++) check_bypass();

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
  import decode_pkg::*;
#(
  parameter int REG_COUNT = 32
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       fetch_valid,
  input  fetch_pkt_t fetch_pkt,
  output logic       fetch_ready,
  output logic       issue_valid,
  output issue_pkt_t issue_pkt,
  input  logic       issue_ready,
  input  logic       wb_en,
  input  reg_idx_t   wb_addr,
  input  xlen_t      wb_data
);

  logic buf_valid;
  logic buf_ready;
  fetch_pkt_t buf_pkt;
  decoder_in_type dec_in;
  decoder_out_type dec_out;
  xlen_t rdata1;
  xlen_t rdata2;

  assign dec_in.instr = buf_pkt.instr;

  instr_buffer buffer_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .fetch_valid (fetch_valid),
    .fetch_pkt   (fetch_pkt),
    .fetch_ready (fetch_ready),
    .buf_valid   (buf_valid),
    .buf_pkt     (buf_pkt),
    .buf_ready   (buf_ready)
  );

  decoder decoder_i (
    .decoder_in  (dec_in),
    .decoder_out (dec_out)
  );

  int_regfile #(
    .REG_COUNT (REG_COUNT)
  ) regfile_i (
    .clock   (clock),
    .arst_n  (arst_n),
    .raddr1  (dec_out.raddr1),
    .raddr2  (dec_out.raddr2),
    .rden1   (dec_out.rden1),
    .rden2   (dec_out.rden2),
    .wb_en   (wb_en),
    .wb_addr (wb_addr),
    .wb_data (wb_data),
    .rdata1  (rdata1),
    .rdata2  (rdata2)
  );

  issue_reg issue_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .buf_valid   (buf_valid),
    .buf_pkt     (buf_pkt),
    .buf_ready   (buf_ready),
    .ctrl        (dec_out),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .issue_valid (issue_valid),
    .issue_pkt   (issue_pkt),
    .issue_ready (issue_ready)
  );

endmodule

// ==== design/issue_reg.sv ====
`timescale 1ns/1ps

module issue_reg
  import decode_pkg::*;
(
  input  logic            clock,
  input  logic            arst_n,
  input  logic            buf_valid,
  input  fetch_pkt_t      buf_pkt,
  output logic            buf_ready,
  input  decoder_out_type ctrl,
  input  xlen_t           rdata1,
  input  xlen_t           rdata2,
  output logic            issue_valid,
  output issue_pkt_t      issue_pkt,
  input  logic            issue_ready
);

  logic load;

  // Take a new item when empty or when the current one leaves.
  assign buf_ready = ~issue_valid | issue_ready;
  assign load = buf_valid & buf_ready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
    end else if (load) begin
      issue_valid <= 1'b1;
    end else if (issue_ready) begin
      issue_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      issue_pkt.pc <= buf_pkt.pc;
      issue_pkt.ctrl <= ctrl;
      issue_pkt.rs1_data <= rdata1;
      issue_pkt.rs2_data <= rdata2;
    end
  end

endmodule

// ==== design/int_regfile.sv ====
`timescale 1ns/1ps

module int_regfile
  import decode_pkg::*;
#(
  parameter int REG_COUNT = 32
) (
  input  logic     clock,
  input  logic     arst_n,
  input  reg_idx_t raddr1,
  input  reg_idx_t raddr2,
  input  logic     rden1,
  input  logic     rden2,
  input  logic     wb_en,
  input  reg_idx_t wb_addr,
  input  xlen_t    wb_data,
  output xlen_t    rdata1,
  output xlen_t    rdata2
);

  xlen_t regs [REG_COUNT];

  // Same-cycle writes bypass the array. x0 and disabled ports read zero.
  function automatic xlen_t read_port(input reg_idx_t addr, input logic en);
    xlen_t data;
    data = regs[addr];
    if (wb_en && wb_addr == addr) begin
      data = wb_data;
    end
    if (!en || addr == '0) begin
      data = '0;
    end
    return data;
  endfunction

  always_comb begin
    rdata1 = read_port(raddr1, rden1);
    rdata2 = read_port(raddr2, rden2);
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && wb_addr != '0) begin
      regs[wb_addr] <= wb_data; // x0 never written.
    end
  end

endmodule

// ==== design/decoder.sv ====
`timescale 1ns/1ps

module decoder
  import decode_pkg::*;
(
  input  decoder_in_type  decoder_in,
  output decoder_out_type decoder_out
);

  instr_t instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  xlen_t imm_c;
  xlen_t imm_i;
  xlen_t imm_s;
  xlen_t imm_b;
  xlen_t imm_u;
  xlen_t imm_j;
  logic nonzero_waddr;
  logic nonzero_raddr1;

  assign instr = decoder_in.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  // Immediate forms.
  assign imm_c = {27'b0, instr[19:15]};
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign nonzero_waddr = |instr[11:7];
  assign nonzero_raddr1 = |instr[19:15];

  always_comb begin
    decoder_out = '0;
    decoder_out.waddr = instr[11:7];
    decoder_out.raddr1 = instr[19:15];
    decoder_out.raddr2 = instr[24:20];
    decoder_out.caddr = instr[31:20];
    decoder_out.valid = 1'b1;

    case (opcode)
      opcode_lui, opcode_auipc : begin
        decoder_out.imm = imm_u;
        decoder_out.wren = nonzero_waddr;
        decoder_out.lui = (opcode == opcode_lui);
        decoder_out.auipc = (opcode == opcode_auipc);
      end
      opcode_jal : begin
        decoder_out.imm = imm_j;
        decoder_out.wren = nonzero_waddr;
        decoder_out.jal = 1'b1;
      end
      opcode_jalr : begin
        decoder_out.imm = imm_i;
        decoder_out.wren = nonzero_waddr;
        decoder_out.rden1 = 1'b1;
        decoder_out.jalr = 1'b1;
      end
      opcode_branch : begin
        decoder_out.imm = imm_b;
        decoder_out.rden1 = 1'b1;
        decoder_out.rden2 = 1'b1;
        decoder_out.branch = 1'b1;
        case (funct3)
          funct_beq  : decoder_out.bcu_op.bcu_beq = 1'b1;
          funct_bne  : decoder_out.bcu_op.bcu_bne = 1'b1;
          funct_blt  : decoder_out.bcu_op.bcu_blt = 1'b1;
          funct_bge  : decoder_out.bcu_op.bcu_bge = 1'b1;
          funct_bltu : decoder_out.bcu_op.bcu_bltu = 1'b1;
          funct_bgeu : decoder_out.bcu_op.bcu_bgeu = 1'b1;
          default    : decoder_out.valid = 1'b0;
        endcase
      end
      opcode_load : begin
        decoder_out.imm = imm_i;
        decoder_out.wren = nonzero_waddr;
        decoder_out.rden1 = 1'b1;
        decoder_out.load = 1'b1;
        case (funct3)
          funct_lb  : decoder_out.lsu_op.lsu_lb = 1'b1;
          funct_lh  : decoder_out.lsu_op.lsu_lh = 1'b1;
          funct_lw  : decoder_out.lsu_op.lsu_lw = 1'b1;
          funct_lbu : decoder_out.lsu_op.lsu_lbu = 1'b1;
          funct_lhu : decoder_out.lsu_op.lsu_lhu = 1'b1;
          default   : decoder_out.valid = 1'b0;
        endcase
      end
      opcode_store : begin
        decoder_out.imm = imm_s;
        decoder_out.rden1 = 1'b1;
        decoder_out.rden2 = 1'b1;
        decoder_out.store = 1'b1;
        case (funct3)
          funct_sb : decoder_out.lsu_op.lsu_sb = 1'b1;
          funct_sh : decoder_out.lsu_op.lsu_sh = 1'b1;
          funct_sw : decoder_out.lsu_op.lsu_sw = 1'b1;
          default  : decoder_out.valid = 1'b0;
        endcase
      end
      opcode_immediate, opcode_register : begin
        decoder_out.imm = (opcode == opcode_immediate) ? imm_i : '0;
        decoder_out.wren = nonzero_waddr;
        decoder_out.rden1 = 1'b1;
        decoder_out.rden2 = (opcode == opcode_register);
        if (opcode == opcode_register && instr[25]) begin
          decoder_out.mul = ~funct3[2]; // M extension.
          decoder_out.div = funct3[2];
          case (funct3)
            funct_mul    : decoder_out.mul_op.mul = 1'b1;
            funct_mulh   : decoder_out.mul_op.mulh = 1'b1;
            funct_mulhsu : decoder_out.mul_op.mulhsu = 1'b1;
            funct_mulhu  : decoder_out.mul_op.mulhu = 1'b1;
            funct_div    : decoder_out.div_op.div = 1'b1;
            funct_divu   : decoder_out.div_op.divu = 1'b1;
            funct_rem    : decoder_out.div_op.rem = 1'b1;
            default      : decoder_out.div_op.remu = 1'b1;
          endcase
        end else begin
          case (funct3)
            funct_add : begin
              // No subtract form for addi.
              decoder_out.alu_op.alu_sub = instr[30] & (opcode == opcode_register);
              decoder_out.alu_op.alu_add = ~decoder_out.alu_op.alu_sub;
            end
            funct_sll  : decoder_out.alu_op.alu_sll = 1'b1;
            funct_slt  : decoder_out.alu_op.alu_slt = 1'b1;
            funct_sltu : decoder_out.alu_op.alu_sltu = 1'b1;
            funct_xor  : decoder_out.alu_op.alu_xor = 1'b1;
            funct_srl  : begin
              decoder_out.alu_op.alu_srl = ~instr[30];
              decoder_out.alu_op.alu_sra = instr[30];
            end
            funct_or   : decoder_out.alu_op.alu_or = 1'b1;
            default    : decoder_out.alu_op.alu_and = 1'b1;
          endcase
          // Shift amount is five bits on RV32.
          if (opcode == opcode_immediate && (funct3 == funct_sll || funct3 == funct_srl)) begin
            decoder_out.valid = ~instr[25];
          end
        end
      end
      opcode_fence : begin
        decoder_out.fence = (funct3 == 3'b000) || (funct3 == 3'b001);
        decoder_out.valid = decoder_out.fence;
      end
      opcode_system : begin
        decoder_out.imm = imm_c;
        if (funct3 == 3'b000) begin
          case (instr[31:20])
            csr_ecall  : decoder_out.ecall = 1'b1;
            csr_ebreak : decoder_out.ebreak = 1'b1;
            csr_mret   : decoder_out.mret = 1'b1;
            csr_wfi    : decoder_out.wfi = 1'b1;
            default    : decoder_out.valid = 1'b0;
          endcase
        end else if (funct3 == 3'b100) begin
          decoder_out.valid = 1'b0;
        end else begin
          decoder_out.csr = 1'b1;
          decoder_out.wren = nonzero_waddr;
          decoder_out.rden1 = ~funct3[2]; // Register source forms only.
          case (funct3)
            3'b001 : decoder_out.csr_op.csrrw = 1'b1;
            3'b010 : decoder_out.csr_op.csrrs = 1'b1;
            3'b011 : decoder_out.csr_op.csrrc = 1'b1;
            3'b101 : decoder_out.csr_op.csrrwi = 1'b1;
            3'b110 : decoder_out.csr_op.csrrsi = 1'b1;
            default : decoder_out.csr_op.csrrci = 1'b1;
          endcase
          if (funct3[1:0] == 2'b01) begin
            decoder_out.cwren = 1'b1;
            decoder_out.crden = nonzero_waddr;
          end else begin
            decoder_out.cwren = nonzero_raddr1; // Register or immediate source.
            decoder_out.crden = 1'b1;
          end
        end
      end
      default : decoder_out.valid = 1'b0;
    endcase

    if (instr == nop_instr) begin
      decoder_out.alu_op = init_alu_op;
      decoder_out.nop = 1'b1;
    end
  end

endmodule

// ==== design/instr_buffer.sv ====
`timescale 1ns/1ps

module instr_buffer
  import decode_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       fetch_valid,
  input  fetch_pkt_t fetch_pkt,
  output logic       fetch_ready,
  output logic       buf_valid,
  output fetch_pkt_t buf_pkt,
  input  logic       buf_ready
);

  fetch_pkt_t skid_pkt;
  logic skid_valid;
  logic accept;
  logic drain;
  logic main_valid_n;
  logic skid_valid_n;
  logic main_load;
  logic main_from_skid;
  logic skid_load;

  assign accept = fetch_valid & fetch_ready;
  assign drain = buf_valid & buf_ready;

  always_comb begin
    main_valid_n = buf_valid;
    skid_valid_n = skid_valid;
    main_load = 1'b0;
    main_from_skid = 1'b0;
    skid_load = 1'b0;
    if (drain) begin
      if (skid_valid) begin
        main_load = 1'b1; // Refill from skid entry.
        main_from_skid = 1'b1;
        skid_valid_n = 1'b0;
      end else begin
        main_load = accept;
        main_valid_n = accept;
      end
    end else if (accept) begin
      if (buf_valid) begin
        skid_load = 1'b1;
        skid_valid_n = 1'b1;
      end else begin
        main_load = 1'b1;
        main_valid_n = 1'b1;
      end
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      buf_valid <= 1'b0;
      skid_valid <= 1'b0;
      fetch_ready <= 1'b0;
    end else begin
      buf_valid <= main_valid_n;
      skid_valid <= skid_valid_n;
      fetch_ready <= ~skid_valid_n; // Low only with both entries full.
    end
  end

  always_ff @(posedge clock) begin
    if (main_load) begin
      buf_pkt <= main_from_skid ? skid_pkt : fetch_pkt;
    end
    if (skid_load) begin
      skid_pkt <= fetch_pkt;
    end
  end

endmodule

// ==== design/decode_pkg.sv ====
package decode_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [31:0] pc_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [11:0] csr_addr_t;

  // Major opcodes.
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_immediate = 7'b0010011;
  localparam logic [6:0] opcode_register = 7'b0110011;
  localparam logic [6:0] opcode_fence = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  localparam logic [2:0] funct_beq = 3'b000;
  localparam logic [2:0] funct_bne = 3'b001;
  localparam logic [2:0] funct_blt = 3'b100;
  localparam logic [2:0] funct_bge = 3'b101;
  localparam logic [2:0] funct_bltu = 3'b110;
  localparam logic [2:0] funct_bgeu = 3'b111;

  localparam logic [2:0] funct_lb = 3'b000;
  localparam logic [2:0] funct_lh = 3'b001;
  localparam logic [2:0] funct_lw = 3'b010;
  localparam logic [2:0] funct_lbu = 3'b100;
  localparam logic [2:0] funct_lhu = 3'b101;
  localparam logic [2:0] funct_sb = 3'b000;
  localparam logic [2:0] funct_sh = 3'b001;
  localparam logic [2:0] funct_sw = 3'b010;

  localparam logic [2:0] funct_add = 3'b000;
  localparam logic [2:0] funct_sll = 3'b001;
  localparam logic [2:0] funct_slt = 3'b010;
  localparam logic [2:0] funct_sltu = 3'b011;
  localparam logic [2:0] funct_xor = 3'b100;
  localparam logic [2:0] funct_srl = 3'b101;
  localparam logic [2:0] funct_or = 3'b110;
  localparam logic [2:0] funct_and = 3'b111;

  localparam logic [2:0] funct_mul = 3'b000;
  localparam logic [2:0] funct_mulh = 3'b001;
  localparam logic [2:0] funct_mulhsu = 3'b010;
  localparam logic [2:0] funct_mulhu = 3'b011;
  localparam logic [2:0] funct_div = 3'b100;
  localparam logic [2:0] funct_divu = 3'b101;
  localparam logic [2:0] funct_rem = 3'b110;
  localparam logic [2:0] funct_remu = 3'b111;

  // System codes in the csr field with funct3 zero.
  localparam csr_addr_t csr_ecall = 12'h000;
  localparam csr_addr_t csr_ebreak = 12'h001;
  localparam csr_addr_t csr_wfi = 12'h105;
  localparam csr_addr_t csr_mret = 12'h302;

  localparam instr_t nop_instr = 32'h0000_0013; // addi x0,x0,0

  typedef struct packed {
    logic alu_add;
    logic alu_sub;
    logic alu_sll;
    logic alu_srl;
    logic alu_sra;
    logic alu_slt;
    logic alu_sltu;
    logic alu_and;
    logic alu_or;
    logic alu_xor;
  } alu_op_type;

  typedef struct packed {
    logic bcu_beq;
    logic bcu_bne;
    logic bcu_blt;
    logic bcu_bge;
    logic bcu_bltu;
    logic bcu_bgeu;
  } bcu_op_type;

  typedef struct packed {
    logic lsu_lb;
    logic lsu_lbu;
    logic lsu_lh;
    logic lsu_lhu;
    logic lsu_lw;
    logic lsu_sb;
    logic lsu_sh;
    logic lsu_sw;
  } lsu_op_type;

  typedef struct packed {
    logic csrrw;
    logic csrrs;
    logic csrrc;
    logic csrrwi;
    logic csrrsi;
    logic csrrci;
  } csr_op_type;

  typedef struct packed {
    logic mul;
    logic mulh;
    logic mulhsu;
    logic mulhu;
  } mul_op_type;

  typedef struct packed {
    logic div;
    logic divu;
    logic rem;
    logic remu;
  } div_op_type;

  localparam alu_op_type init_alu_op = '0;
  localparam bcu_op_type init_bcu_op = '0;
  localparam lsu_op_type init_lsu_op = '0;
  localparam csr_op_type init_csr_op = '0;
  localparam mul_op_type init_mul_op = '0;
  localparam div_op_type init_div_op = '0;

  typedef struct packed {
    pc_t pc;
    instr_t instr;
  } fetch_pkt_t;

  typedef struct packed {
    instr_t instr;
  } decoder_in_type;

  typedef struct packed {
    xlen_t imm;
    reg_idx_t waddr;
    reg_idx_t raddr1;
    reg_idx_t raddr2;
    csr_addr_t caddr;
    logic wren;
    logic rden1;
    logic rden2;
    logic cwren;
    logic crden;
    logic auipc;
    logic lui;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic nop;
    logic csr;
    logic mul;
    logic div;
    alu_op_type alu_op;
    bcu_op_type bcu_op;
    lsu_op_type lsu_op;
    csr_op_type csr_op;
    mul_op_type mul_op;
    div_op_type div_op;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic valid;
  } decoder_out_type;

  typedef struct packed {
    pc_t pc;
    decoder_out_type ctrl;
    xlen_t rs1_data;
    xlen_t rs2_data;
  } issue_pkt_t;

endpackage
